//--- Bender.yml
package:
  name: vdc_core

sources:
  # Design, in compile order
  - files:
      - rtl/vdc_reg_pkg.sv
      - rtl/vdc_video_pkg.sv
      - rtl/vdc_timing_if.sv
      - rtl/vdc_vram.sv
      - rtl/vdc_cpu_port.sv
      - rtl/vdc_timing_gen.sv
      - rtl/vdc_vram_arbiter.sv
      - rtl/vdc_bg_fetch.sv
      - rtl/vdc_top.sv
  # Testbench
  - target: simulation
    include_dirs:
      - tests
    files:
      - tests/tb_vdc.sv

//--- rtl/vdc_bg_fetch.sv
`timescale 1ns/100ps

module vdc_bg_fetch import vdc_reg_pkg::*, vdc_video_pkg::*; (
  input  logic          clock,
  input  logic          reset_N,
  vdc_timing_if.sink    timing,
  input  logic [1:0]    mwr_width,
  input  logic          cr_bg_en,
  input  word_t         vram_rdata,
  output word_t         bg_addr,
  output logic          bg_fetch_active,
  output pixel_t        vd
);

  localparam int PTR_W = $clog2(BG_PIPE_LEN);

  logic [3:0]       pipe_pal [BG_PIPE_LEN];
  word_t            pipe_cg0 [BG_PIPE_LEN];  // Planes 0 and 1
  word_t            pipe_cg1 [BG_PIPE_LEN];  // Planes 2 and 3
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  line_cnt_t        cur_row;                 // Display line, in pixels
  logic [6:0]       cur_col;                 // BAT column, in tiles
  logic [6:0]       col_mask;
  logic [2:0]       row_shift;
  word_t            bat_addr;
  word_t            tile_ptr;
  bat_entry_t       bat;
  logic             fetch_q;                 // Fetch window, one clock late
  char_cycle_t      slot_q;
  char_cycle_t      cc;
  logic             in_disp;
  logic             line_end;
  logic [3:0]       tile_pix;

  assign cc  = timing.char_cycle;
  assign bat = vram_rdata;

  // Display plus the last two characters before it
  assign bg_fetch_active = (timing.v_state == V_DISP) &&
                           ((timing.h_state == H_DISP) ||
                            (timing.h_state == H_WAIT && timing.h_cnt < 10'd2));
  assign in_disp  = (timing.v_state == V_DISP) && (timing.h_state == H_DISP);
  assign line_end = in_disp && (timing.h_cnt == '0) && (cc == 3'd7);

  // BAT is 32, 64 or 128 tiles wide
  assign row_shift = mwr_width[1] ? 3'd7 : (mwr_width[0] ? 3'd6 : 3'd5);
  assign col_mask  = 7'h7F >> (3'd7 - row_shift);
  assign bat_addr  = word_t'(cur_col) + (word_t'(cur_row[9:3]) << row_shift);

  always_comb begin
    case (cc)
      3'd1:    bg_addr = bat_addr;                          // BAT word
      3'd7:    bg_addr = tile_ptr + word_t'(CG1_OFFSET);    // CG1
      default: bg_addr = tile_ptr;                          // CG0 at slot 5
    endcase
  end

  ////////////////////////////////////////////////////////////////////////////
  // Pointers and BAT position

  always_ff @(posedge clock, negedge reset_N) begin
    if (~reset_N) begin
      fetch_q <= 1'b0;
      slot_q  <= '0;
      wr_ptr  <= '0;
      rd_ptr  <= '0;
      cur_row <= '0;
      cur_col <= '0;
    end else begin
      fetch_q <= bg_fetch_active;
      slot_q  <= cc;
      // Write side moves once the CG1 word has landed
      if (!fetch_q)
        wr_ptr <= '0;
      else if (slot_q == 3'd7)
        wr_ptr <= (wr_ptr == PTR_W'(BG_PIPE_LEN - 1)) ? '0 : wr_ptr + 1'b1;
      if (!in_disp)
        rd_ptr <= '0;
      else if (cc == 3'd7)
        rd_ptr <= (rd_ptr == PTR_W'(BG_PIPE_LEN - 1)) ? '0 : rd_ptr + 1'b1;
      if (timing.v_state == V_WAIT)
        cur_row <= '0;
      else if (line_end)
        cur_row <= cur_row + 10'd1;
      if (timing.h_state == H_SYNC)
        cur_col <= '0;
      else if (bg_fetch_active && cc == 3'd7)
        cur_col <= (cur_col + 7'd1) & col_mask;  // Wrap inside the BAT row
    end
  end

  // Pipe fill, data arrives the clock after its slot
  always_ff @(posedge clock) begin
    if (fetch_q) begin
      case (slot_q)
        3'd1: begin
          pipe_pal[wr_ptr] <= bat[15:12];
          tile_ptr         <= {bat[11:0], 4'h0} + word_t'(cur_row[2:0]);
        end
        3'd5:    pipe_cg0[wr_ptr] <= vram_rdata;
        3'd7:    pipe_cg1[wr_ptr] <= vram_rdata;
        default: ;
      endcase
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Pixel out, leftmost dot in the high bit of each plane byte

  assign tile_pix = {pipe_cg1[rd_ptr][{1'b1, ~cc}], pipe_cg1[rd_ptr][{1'b0, ~cc}],
                     pipe_cg0[rd_ptr][{1'b1, ~cc}], pipe_cg0[rd_ptr][{1'b0, ~cc}]};

  always_comb begin
    if (!in_disp)
      vd = OVERSCAN_PIXEL;
    else if (tile_pix == 4'd0 || !cr_bg_en)
      vd = {1'b0, 4'd0, tile_pix};           // Transparent or background off
    else
      vd = {1'b0, pipe_pal[rd_ptr], tile_pix};
  end

  assert property (@(posedge clock) disable iff (~reset_N)
    (wr_ptr < BG_PIPE_LEN) && (rd_ptr < BG_PIPE_LEN));

endmodule

//--- rtl/vdc_cpu_port.sv
`timescale 1ns/100ps

module vdc_cpu_port import vdc_reg_pkg::*; (
  input  logic         clock,
  input  logic         reset_N,
  input  logic         cs_n,
  input  logic         rd_n,
  input  logic         wr_n,
  input  bus_port_t    a,
  input  byte_t        data_in,
  output byte_t        data_out,
  output logic         irq_n,
  output logic         busy_n,
  vdc_mem_if.cpu       mem,
  vdc_timing_if.sink   timing,
  output logic [1:0]   mwr_width,
  output logic         cr_bg_en
);

  logic       rd;
  logic       wr;
  logic       prev_rd;
  logic       prev_wr;
  logic       rd_edge;
  logic       wr_edge;
  logic       ack;          // Status read, clears the interrupt
  reg_sel_t   regnum;
  word_t      mawr;
  word_t      marr;
  word_t      vwr;
  word_t      cr;
  word_t      addr_step;
  byte_t      mwr;
  byte_t      status;
  addr_incr_t incr_sel;

  assign rd      = ~rd_n & ~cs_n;  // Active high strobes
  assign wr      = ~wr_n & ~cs_n;
  assign rd_edge = rd & ~prev_rd;
  assign wr_edge = wr & ~prev_wr;
  assign ack     = rd_edge & (a == A_STATUS);

  always_ff @(posedge clock, negedge reset_N) begin
    if (~reset_N) begin
      prev_rd <= 1'b0;
      prev_wr <= 1'b0;
    end else begin
      prev_rd <= rd;
      prev_wr <= wr;
    end
  end

  assign incr_sel = cr[CR_INCR_LSB +: 2];

  always_comb begin
    case (incr_sel)
      ADDR_INCR_1:  addr_step = 16'd1;
      ADDR_INCR_32: addr_step = 16'd32;
      ADDR_INCR_64: addr_step = 16'd64;
      default:      addr_step = 16'd128;
    endcase
  end

  ////////////////////////////////////////////////////////////////////////////
  // Register file

  always_ff @(posedge clock, negedge reset_N) begin
    if (~reset_N) begin
      regnum <= REG_MAWR;
      mawr   <= '0;
      marr   <= '0;
      cr     <= '0;
      mwr    <= '0;
    end else begin
      // Step after each access, a CPU write in the same cycle wins
      if (mem.read_issue)
        marr <= marr + addr_step;
      if (mem.write_issue)
        mawr <= mawr + addr_step;
      if (wr_edge) begin
        case (a)
          A_STATUS:
            case (data_in[4:0])
              5'd0, 5'd1, 5'd2, 5'd5, 5'd9: regnum <= reg_sel_t'(data_in[4:0]);
              default: ;  // Unsupported register, selection kept
            endcase
          A_DATA_LSB:
            case (regnum)
              REG_MAWR: mawr[7:0] <= data_in;
              REG_MARR: marr[7:0] <= data_in;
              REG_CR:   cr[7:0]   <= data_in;
              REG_MWR:  mwr       <= data_in;
              default: ;
            endcase
          A_DATA_MSB:
            case (regnum)
              REG_MAWR: mawr[15:8] <= data_in;
              REG_MARR: marr[15:8] <= data_in;  // Also starts a VRAM read
              REG_CR:   cr[12:8]   <= data_in[4:0];
              default: ;
            endcase
          default: ;
        endcase
      end
    end
  end

  // Write buffer, payload only
  always_ff @(posedge clock) begin
    if (wr_edge && regnum == REG_VRR_VWR) begin
      if (a == A_DATA_LSB)
        vwr[7:0] <= data_in;
      else if (a == A_DATA_MSB)
        vwr[15:8] <= data_in;
    end
  end

  // MSB of MARR or VRR triggers a fetch, MSB of VWR a store
  assign mem.read_req   = (a == A_DATA_MSB) &
                          ((rd & (regnum == REG_VRR_VWR)) | (wr & (regnum == REG_MARR)));
  assign mem.write_req  = wr & (a == A_DATA_MSB) & (regnum == REG_VRR_VWR);
  assign mem.read_addr  = marr;
  assign mem.write_addr = mawr;
  assign mem.write_data = vwr;

  assign busy_n    = ~mem.mem_wait;
  assign mwr_width = mwr[MWR_WIDTH_LSB +: 2];
  assign cr_bg_en  = cr[CR_BG_EN_BIT];

  ////////////////////////////////////////////////////////////////////////////
  // Read data and interrupt

  always_ff @(posedge clock, negedge reset_N) begin
    if (~reset_N) begin
      data_out <= '0;
    end else if (rd_edge) begin
      case (a)
        A_STATUS:   data_out <= status;  // Value before the ack clears it
        A_UNUSED:   data_out <= '0;
        A_DATA_LSB: data_out <= (regnum == REG_VRR_VWR) ? mem.read_data[7:0] : '0;
        default:    data_out <= (regnum == REG_VRR_VWR) ? mem.read_data[15:8] : '0;
      endcase
    end
  end

  always_ff @(posedge clock, negedge reset_N) begin
    if (~reset_N) begin
      irq_n  <= 1'b1;
      status <= '0;
    end else if (ack) begin
      irq_n  <= 1'b1;   // Acknowledge beats a new event
      status <= '0;
    end else if (timing.vblank_start && cr[CR_IRQ_VBLANK_BIT]) begin
      irq_n                     <= 1'b0;
      status[STATUS_VBLANK_BIT] <= 1'b1;
    end
  end

  // One access kind per CPU strobe
  assert property (@(posedge clock) disable iff (~reset_N)
    !(mem.read_req && mem.write_req));

endmodule

//--- rtl/vdc_reg_pkg.sv
// CPU side of the VDC: register numbers, bus ports and register fields
package vdc_reg_pkg;

  typedef logic [15:0] word_t;   // VRAM word or VRAM address
  typedef logic [7:0]  byte_t;   // CPU data byte

  // Registers reachable through the address register
  typedef enum logic [4:0] {
    REG_MAWR    = 5'd0,  // Write address
    REG_MARR    = 5'd1,  // Read address
    REG_VRR_VWR = 5'd2,  // Read data / write buffer
    REG_CR      = 5'd5,  // Control
    REG_MWR     = 5'd9   // Memory width
  } reg_sel_t;

  // CPU address lines A1:A0
  typedef logic [1:0] bus_port_t;
  localparam bus_port_t A_STATUS   = 2'd0;  // Status on read, register select on write
  localparam bus_port_t A_UNUSED   = 2'd1;
  localparam bus_port_t A_DATA_LSB = 2'd2;
  localparam bus_port_t A_DATA_MSB = 2'd3;

  // Address step after each VRAM access, CR[12:11]
  typedef logic [1:0] addr_incr_t;
  localparam addr_incr_t ADDR_INCR_1   = 2'd0;
  localparam addr_incr_t ADDR_INCR_32  = 2'd1;
  localparam addr_incr_t ADDR_INCR_64  = 2'd2;
  localparam addr_incr_t ADDR_INCR_128 = 2'd3;

  localparam int CR_INCR_LSB       = 11;
  localparam int CR_IRQ_VBLANK_BIT = 3;  // Vblank interrupt enable
  localparam int CR_BG_EN_BIT      = 7;  // Background enable
  localparam int STATUS_VBLANK_BIT = 5;
  localparam int MWR_WIDTH_LSB     = 4;  // Two bits, BAT width 32/64/128

endpackage

//--- rtl/vdc_timing_gen.sv
`timescale 1ns/100ps

module vdc_timing_gen import vdc_video_pkg::*; #(
  parameter int H_SYNC_WIDTH = 2,    // Characters, minus one
  parameter int H_START      = 2,
  parameter int H_DISP_TILES = 31,
  parameter int H_END_LEN    = 3,
  parameter int V_SYNC_WIDTH = 2,    // Lines, minus one
  parameter int V_START      = 15,   // Minus two
  parameter int V_DISP_LINES = 239,
  parameter int V_END_LEN    = 3     // Plain line count
) (
  input  logic          clock,
  input  logic          reset_N,
  vdc_timing_if.source  timing,
  output logic          hsync_n,
  output logic          vsync_n
);

  char_cycle_t char_cycle;
  h_state_t    h_state;
  v_state_t    v_state;
  line_cnt_t   h_cnt;
  line_cnt_t   v_cnt;
  logic        eol;           // Last dot of the line
  logic        vblank_start;

  assign eol = (char_cycle == 3'd7) && (h_state == H_END) && (h_cnt == '0);

  always_ff @(posedge clock, negedge reset_N) begin
    if (~reset_N)
      char_cycle <= '0;
    else
      char_cycle <= char_cycle + 3'd1;  // One dot per clock
  end

  // Horizontal phases, stepped once per character
  always_ff @(posedge clock, negedge reset_N) begin
    if (~reset_N) begin
      h_state <= H_SYNC;
      h_cnt   <= line_cnt_t'(H_SYNC_WIDTH);
    end else if (char_cycle == 3'd7) begin
      h_cnt <= h_cnt - 10'd1;
      if (h_cnt == '0) begin
        case (h_state)
          H_SYNC: begin h_state <= H_WAIT; h_cnt <= line_cnt_t'(H_START);      end
          H_WAIT: begin h_state <= H_DISP; h_cnt <= line_cnt_t'(H_DISP_TILES); end
          H_DISP: begin h_state <= H_END;  h_cnt <= line_cnt_t'(H_END_LEN);    end
          default: begin h_state <= H_SYNC; h_cnt <= line_cnt_t'(H_SYNC_WIDTH); end
        endcase
      end
    end
  end

  // Vertical phases, stepped at the end of each line
  always_ff @(posedge clock, negedge reset_N) begin
    if (~reset_N) begin
      v_state      <= V_WAIT;
      v_cnt        <= line_cnt_t'(V_START + 1);
      vblank_start <= 1'b0;
    end else begin
      vblank_start <= eol && (v_state == V_DISP) && (v_cnt == '0);
      if (eol) begin
        v_cnt <= v_cnt - 10'd1;
        if (v_cnt == '0) begin
          case (v_state)
            V_SYNC: begin v_state <= V_WAIT; v_cnt <= line_cnt_t'(V_START + 1);   end
            V_WAIT: begin v_state <= V_DISP; v_cnt <= line_cnt_t'(V_DISP_LINES);  end
            V_DISP: begin v_state <= V_END;  v_cnt <= line_cnt_t'(V_END_LEN - 1); end
            default: begin v_state <= V_SYNC; v_cnt <= line_cnt_t'(V_SYNC_WIDTH); end
          endcase
        end
      end
    end
  end

  assign hsync_n = (h_state != H_SYNC);
  assign vsync_n = (v_state != V_SYNC);

  assign timing.char_cycle   = char_cycle;
  assign timing.h_state      = h_state;
  assign timing.v_state      = v_state;
  assign timing.h_cnt        = h_cnt;
  assign timing.v_cnt        = v_cnt;
  assign timing.vblank_start = vblank_start;

  // Phases only move on a character boundary
  assert property (@(posedge clock) disable iff (~reset_N)
    ($changed(h_state) || $changed(v_state)) |-> ($past(char_cycle) == 3'd7));

endmodule

//--- rtl/vdc_timing_if.sv
`timescale 1ns/100ps

// Raster position from the timing generator to every consumer
interface vdc_timing_if import vdc_video_pkg::*; ();
  char_cycle_t char_cycle;
  h_state_t    h_state;
  v_state_t    v_state;
  line_cnt_t   h_cnt;         // Characters left in the phase
  line_cnt_t   v_cnt;         // Lines left in the phase
  logic        vblank_start;  // Single cycle as V_DISP ends

  modport source (output char_cycle, h_state, v_state, h_cnt, v_cnt, vblank_start);
  modport sink   (input  char_cycle, h_state, v_state, h_cnt, v_cnt, vblank_start);
endinterface

// CPU port to VRAM arbiter, requests are levels and issues are pulses
interface vdc_mem_if import vdc_reg_pkg::*; ();
  logic  read_req;
  logic  write_req;
  word_t read_addr;    // MARR
  word_t write_addr;   // MAWR
  word_t write_data;   // VWR
  logic  read_issue;
  logic  write_issue;
  word_t read_data;    // Held until the next read issue
  logic  mem_wait;

  modport cpu (output read_req, write_req, read_addr, write_addr, write_data,
               input  read_issue, write_issue, read_data, mem_wait);
  modport arbiter (input  read_req, write_req, read_addr, write_addr, write_data,
                   output read_issue, write_issue, read_data, mem_wait);
endinterface

//--- rtl/vdc_top.sv
`timescale 1ns/100ps

module vdc_top import vdc_reg_pkg::*, vdc_video_pkg::*; #(
  parameter int H_SYNC_WIDTH = 2,
  parameter int H_START      = 2,
  parameter int H_DISP_TILES = 31,
  parameter int H_END_LEN    = 3,
  parameter int V_SYNC_WIDTH = 2,
  parameter int V_START      = 15,
  parameter int V_DISP_LINES = 239,
  parameter int V_END_LEN    = 3
) (
  input  logic      clock,
  input  logic      reset_N,
  input  logic      cs_n,
  input  logic      rd_n,
  input  logic      wr_n,
  input  bus_port_t a,
  input  byte_t     data_in,
  output byte_t     data_out,
  output logic      busy_n,
  output logic      irq_n,
  output logic      hsync_n,
  output logic      vsync_n,
  output pixel_t    vd
);

  vdc_timing_if timing_bus ();
  vdc_mem_if    mem_bus ();

  word_t      bg_addr;
  word_t      vram_rdata;
  logic       bg_fetch_active;
  logic       cr_bg_en;
  logic [1:0] mwr_width;

  vdc_cpu_port u_cpu_port (
    .clock     (clock),
    .reset_N   (reset_N),
    .cs_n      (cs_n),
    .rd_n      (rd_n),
    .wr_n      (wr_n),
    .a         (a),
    .data_in   (data_in),
    .data_out  (data_out),
    .irq_n     (irq_n),
    .busy_n    (busy_n),
    .mem       (mem_bus.cpu),
    .timing    (timing_bus.sink),
    .mwr_width (mwr_width),
    .cr_bg_en  (cr_bg_en)
  );

  vdc_timing_gen #(
    .H_SYNC_WIDTH (H_SYNC_WIDTH),
    .H_START      (H_START),
    .H_DISP_TILES (H_DISP_TILES),
    .H_END_LEN    (H_END_LEN),
    .V_SYNC_WIDTH (V_SYNC_WIDTH),
    .V_START      (V_START),
    .V_DISP_LINES (V_DISP_LINES),
    .V_END_LEN    (V_END_LEN)
  ) u_timing_gen (
    .clock   (clock),
    .reset_N (reset_N),
    .timing  (timing_bus.source),
    .hsync_n (hsync_n),
    .vsync_n (vsync_n)
  );

  vdc_vram_arbiter u_vram_arbiter (
    .clock           (clock),
    .reset_N         (reset_N),
    .mem             (mem_bus.arbiter),
    .timing          (timing_bus.sink),
    .bg_addr         (bg_addr),
    .bg_fetch_active (bg_fetch_active),
    .vram_rdata      (vram_rdata)
  );

  vdc_bg_fetch u_bg_fetch (
    .clock           (clock),
    .reset_N         (reset_N),
    .timing          (timing_bus.sink),
    .mwr_width       (mwr_width),
    .cr_bg_en        (cr_bg_en),
    .vram_rdata      (vram_rdata),
    .bg_addr         (bg_addr),
    .bg_fetch_active (bg_fetch_active),
    .vd              (vd)
  );

endmodule

//--- rtl/vdc_video_pkg.sv
// Raster side of the VDC: timing states, tile and pixel formats
package vdc_video_pkg;

  // Horizontal line phases, in this order
  typedef enum logic [1:0] {
    H_SYNC,
    H_WAIT,
    H_DISP,
    H_END
  } h_state_t;

  // Vertical frame phases, in this order
  typedef enum logic [1:0] {
    V_SYNC,
    V_WAIT,
    V_DISP,
    V_END
  } v_state_t;

  typedef logic [2:0] char_cycle_t;  // Dot inside an 8-dot character
  typedef logic [9:0] line_cnt_t;    // Phase counter, counts down

  // VD: [8] sprite select, [7:4] palette, [3:0] colour
  typedef logic [8:0] pixel_t;

  // BAT word: [15:12] palette, [11:0] tile index
  typedef logic [15:0] bat_entry_t;

  localparam int     BG_PIPE_LEN    = 3;       // Two ahead plus the one on screen
  localparam int     CG1_OFFSET     = 8;       // Planes 2/3 sit 8 words after planes 0/1
  localparam pixel_t OVERSCAN_PIXEL = 9'h100;  // Sprite palette 0, colour 0

endpackage

//--- rtl/vdc_vram.sv
`timescale 1ns/100ps

// 64K x 16 video memory, read data one clock after the address
module vdc_vram import vdc_reg_pkg::*; (
  input  logic  clock,
  input  word_t addr,
  input  logic  we,
  input  word_t wdata,
  output word_t rdata
);

  word_t mem [65536];

  always_ff @(posedge clock) begin
    if (we)
      mem[addr] <= wdata;
    rdata <= mem[addr];  // Old contents on a write cycle
  end

endmodule

//--- rtl/vdc_vram_arbiter.sv
`timescale 1ns/100ps

module vdc_vram_arbiter import vdc_reg_pkg::*; (
  input  logic          clock,
  input  logic          reset_N,
  vdc_mem_if.arbiter    mem,
  vdc_timing_if.sink    timing,
  input  word_t         bg_addr,
  input  logic          bg_fetch_active,
  output word_t         vram_rdata
);

  typedef enum logic [1:0] {
    MEM_IDLE,
    MEM_READ,
    MEM_WRITE
  } mem_state_t;

  mem_state_t state;
  mem_state_t state_next;
  logic       prev_read_req;
  logic       prev_write_req;
  logic       read_pend;
  logic       write_pend;
  logic       read_issue;
  logic       write_issue;
  logic       read_issue_q;  // VRAM data for the CPU is on vram_rdata now
  logic       cpu_slot;
  logic       bg_slot;
  word_t      vram_addr;
  word_t      read_buf;

  // CPU owns even dots outside the background fetch window
  assign cpu_slot = ~timing.char_cycle[0] & ~bg_fetch_active;
  assign bg_slot  = bg_fetch_active &&
                    (timing.char_cycle == 3'd1 || timing.char_cycle == 3'd5 ||
                     timing.char_cycle == 3'd7);

  ////////////////////////////////////////////////////////////////////////////
  // Request capture, at most one read and one write outstanding

  always_ff @(posedge clock, negedge reset_N) begin
    if (~reset_N) begin
      prev_read_req  <= 1'b0;
      prev_write_req <= 1'b0;
      read_pend      <= 1'b0;
      write_pend     <= 1'b0;
      state          <= MEM_IDLE;
      read_issue_q   <= 1'b0;
    end else begin
      prev_read_req  <= mem.read_req;
      prev_write_req <= mem.write_req;
      if (read_issue)
        read_pend <= 1'b0;
      if (mem.read_req && !prev_read_req)
        read_pend <= 1'b1;
      if (write_issue)
        write_pend <= 1'b0;
      if (mem.write_req && !prev_write_req)
        write_pend <= 1'b1;
      state        <= state_next;
      read_issue_q <= read_issue;
    end
  end

  always_comb begin
    state_next  = state;
    read_issue  = 1'b0;
    write_issue = 1'b0;
    case (state)
      MEM_IDLE:
        if (read_pend)
          state_next = MEM_READ;   // Reads go first
        else if (write_pend)
          state_next = MEM_WRITE;
      MEM_READ:
        if (cpu_slot) begin
          read_issue = 1'b1;
          state_next = MEM_IDLE;
        end
      MEM_WRITE:
        if (cpu_slot) begin
          write_issue = 1'b1;
          state_next  = MEM_IDLE;
        end
      default: state_next = MEM_IDLE;
    endcase
  end

  assign mem.read_issue  = read_issue;
  assign mem.write_issue = write_issue;
  assign mem.mem_wait    = (read_pend & ~read_issue) | (write_pend & ~write_issue);

  // Address mux
  always_comb begin
    if (bg_slot)
      vram_addr = bg_addr;
    else if (write_issue)
      vram_addr = mem.write_addr;
    else
      vram_addr = mem.read_addr;
  end

  vdc_vram u_vram (
    .clock (clock),
    .addr  (vram_addr),
    .we    (write_issue),
    .wdata (mem.write_data),
    .rdata (vram_rdata)
  );

  // Hold the CPU word until the next read
  always_ff @(posedge clock) begin
    if (read_issue_q)
      read_buf <= vram_rdata;
  end

  assign mem.read_data = read_issue_q ? vram_rdata : read_buf;

  assert property (@(posedge clock) disable iff (~reset_N)
    !(read_issue && write_issue));

endmodule

//--- tests/tb_vdc_tasks.svh
////////////////////////////////////////////////////////////////////////////
// Failure reporting

task automatic abort_run(input string why);
  $display("%s", why);
  $display("test failed");
  $fatal(1, "run aborted");
endtask

task automatic check_equal(input string name, input logic [31:0] actual,
                           input logic [31:0] expected);
  if (actual !== expected) begin
    $display("** Error: %s is 0x%0h, expected 0x%0h at %0t", name, actual, expected, $time);
    abort_run("A DUT output did not match its expected value");
  end
endtask

////////////////////////////////////////////////////////////////////////////
// CPU bus with strobes held one clock and edge detected by the DUT

task automatic wait_until_idle();
  while (busy_n !== 1'b1)
    @(negedge clock);                   // VRAM access still queued
endtask

task automatic write_port(input bus_port_t port, input byte_t value);
  wait_until_idle();
  @(posedge clock);
  cs_n    <= 1'b0;
  wr_n    <= 1'b0;
  a       <= port;
  data_in <= value;
  @(posedge clock);
  cs_n <= 1'b1;
  wr_n <= 1'b1;
  @(negedge clock);                     // busy_n is valid from here
  wait_until_idle();
endtask

task automatic read_port(input bus_port_t port, output byte_t value);
  wait_until_idle();
  @(posedge clock);
  cs_n <= 1'b0;
  rd_n <= 1'b0;
  a    <= port;
  @(posedge clock);
  cs_n <= 1'b1;
  rd_n <= 1'b1;
  @(negedge clock);
  value = data_out;                     // Latched on the strobe edge
  wait_until_idle();
endtask

task automatic select_reg(input reg_sel_t r);
  write_port(A_STATUS, byte_t'(r));
endtask

task automatic write_reg(input reg_sel_t r, input word_t value);
  select_reg(r);
  write_port(A_DATA_LSB, value[7:0]);
  write_port(A_DATA_MSB, value[15:8]);  // MARR fetch starts here
endtask

// Consecutive words with step 1 set in CR
task automatic fill_vram(input word_t start, input int count, input word_t value);
  int k;
  write_reg(REG_MAWR, start);
  select_reg(REG_VRR_VWR);
  for (k = 0; k < count; k++) begin
    write_port(A_DATA_LSB, value[7:0]);
    write_port(A_DATA_MSB, value[15:8]);
  end
endtask

task automatic wait_hsync_fall();
  do begin
    @(negedge clock);
  end while (hsync_n !== 1'b1);
  do begin
    @(negedge clock);
  end while (hsync_n !== 1'b0);
endtask

task automatic wait_vsync_fall();
  do begin
    @(negedge clock);
  end while (vsync_n !== 1'b1);
  do begin
    @(negedge clock);
  end while (vsync_n !== 1'b0);
endtask

task automatic wait_irq_fall();
  int clocks;
  clocks = 0;
  do begin
    @(negedge clock);
    clocks++;
    if (clocks > 2 * FRAME_CLOCKS)
      abort_run("irq_n did not fall within two frames");
  end while (irq_n !== 1'b0);
endtask

////////////////////////////////////////////////////////////////////////////
// Directed tests

task automatic check_reset_state();
  @(negedge clock);
  check_equal("irq_n", irq_n, 1);
  check_equal("busy_n", busy_n, 1);
  check_equal("data_out", data_out, 0);
  check_equal("hsync_n", hsync_n, 0);   // Raster starts in H_SYNC
  check_equal("vsync_n", vsync_n, 1);   // and in V_WAIT
endtask

task automatic vram_increment_readback();
  int    step [4];
  int    sel;
  int    k;
  word_t start;
  word_t addr;
  word_t data;
  byte_t lo;
  byte_t hi;
  step = '{1, 32, 64, 128};
  for (sel = 0; sel < 4; sel++) begin
    start = word_t'($urandom);
    write_reg(REG_CR, {3'b000, addr_incr_t'(sel), 11'd0});  // Step field at CR[12:11]
    write_reg(REG_MAWR, start);
    select_reg(REG_VRR_VWR);
    for (k = 0; k < WORDS_PER_RUN; k++) begin
      addr             = start + word_t'(k * step[sel]);
      data             = word_t'($urandom);
      vram_model[addr] = data;
      write_port(A_DATA_LSB, data[7:0]);
      write_port(A_DATA_MSB, data[15:8]);
    end
    write_reg(REG_MARR, start);         // First word fetched here
    select_reg(REG_VRR_VWR);
    for (k = 0; k < WORDS_PER_RUN; k++) begin
      addr = start + word_t'(k * step[sel]);
      read_port(A_DATA_LSB, lo);
      read_port(A_DATA_MSB, hi);        // Also fetches the next word
      check_equal("vram word", {hi, lo}, vram_model[addr]);
    end
    // Last word again through a direct MARR load
    addr = start + word_t'((WORDS_PER_RUN - 1) * step[sel]);
    write_reg(REG_MARR, addr);
    select_reg(REG_VRR_VWR);
    read_port(A_DATA_LSB, lo);
    read_port(A_DATA_MSB, hi);
    check_equal("vram word", {hi, lo}, vram_model[addr]);
  end
endtask

task automatic sync_timing_measure();
  int   clocks;
  int   lines;
  logic prev_h;
  wait_hsync_fall();
  clocks = 0;
  do begin
    @(negedge clock);
    clocks++;
  end while (hsync_n !== 1'b1);
  check_equal("hsync_n low clocks", clocks, HSYNC_LOW_CLOCKS);
  do begin
    @(negedge clock);
    clocks++;
  end while (hsync_n !== 1'b0);
  check_equal("hsync_n period clocks", clocks, LINE_CLOCKS);

  // Vertical figures counted in HSYNC falling edges
  wait_vsync_fall();
  lines  = 0;
  prev_h = hsync_n;
  do begin
    @(negedge clock);
    if (prev_h && !hsync_n)
      lines++;
    prev_h = hsync_n;
  end while (vsync_n !== 1'b1);
  check_equal("vsync_n low lines", lines, VSYNC_LOW_LINES);
  do begin
    @(negedge clock);
    if (prev_h && !hsync_n)
      lines++;
    prev_h = hsync_n;
  end while (vsync_n !== 1'b0);
  check_equal("vsync_n period lines", lines, FRAME_LINES);
endtask

task automatic vblank_irq_sequence();
  byte_t status;
  int    first_fall;
  int    i;
  write_reg(REG_CR, 16'h0000);          // Vblank interrupt off
  for (i = 0; i < FRAME_CLOCKS; i++) begin
    @(negedge clock);
    check_equal("irq_n", irq_n, 1);
  end
  write_reg(REG_CR, 16'(1 << CR_IRQ_VBLANK_BIT));
  wait_irq_fall();
  first_fall = cycle_count;
  read_port(A_STATUS, status);          // Acknowledge
  check_equal("status", status, 8'(1 << STATUS_VBLANK_BIT));
  check_equal("irq_n", irq_n, 1);
  read_port(A_STATUS, status);
  check_equal("status", status, 0);
  wait_irq_fall();                      // Next frame
  check_equal("irq_n fall spacing", cycle_count - first_fall, FRAME_CLOCKS);
  read_port(A_STATUS, status);
  write_reg(REG_CR, 16'h0000);
endtask

// One whole frame from a VSYNC fall with every non-overscan dot checked
task automatic sample_frame(input pixel_t expected, output int disp_count);
  int i;
  disp_count = 0;
  wait_vsync_fall();
  for (i = 0; i < FRAME_CLOCKS; i++) begin
    @(negedge clock);
    if (vd !== 9'h100) begin
      check_equal("vd", vd, expected);
      disp_count++;
    end
  end
endtask

task automatic background_pixels();
  logic [3:0]  pal;
  logic [11:0] tile;
  int          disp_count;
  pal  = 4'(1 + $urandom % 15);
  tile = 12'(4 + $urandom % 4000);      // Tile data clear of BAT words 0..63
  write_reg(REG_MWR, 16'h0000);         // 32-tile BAT
  write_reg(REG_CR, 16'(1 << CR_BG_EN_BIT));  // Step 1 with background on
  fill_vram(16'h0000, 64, {pal, tile}); // Rows 0 and 1 of the BAT
  fill_vram({tile, 4'h0}, 16, 16'hFFFF);  // CG0 and CG1 all set
  sample_frame({1'b0, pal, 4'hF}, disp_count);
  check_equal("display dots", disp_count, DISP_DOTS);
  fill_vram({tile, 4'h0}, 16, 16'h0000);
  sample_frame(9'h000, disp_count);     // Transparent so the palette is forced to 0
  check_equal("display dots", disp_count, DISP_DOTS);
endtask

//--- tests/tb_vdc.sv
`timescale 1ns/100ps

module tb_vdc import vdc_reg_pkg::*, vdc_video_pkg::*; ();

  ////////////////////////////////////////////////////////////////////////////
  // Small raster with values stored minus one as in the DUT
  localparam int H_SYNC_WIDTH = 1;
  localparam int H_START      = 1;
  localparam int H_DISP_TILES = 7;
  localparam int H_END_LEN    = 1;
  localparam int V_SYNC_WIDTH = 1;
  localparam int V_START      = 1;
  localparam int V_DISP_LINES = 15;
  localparam int V_END_LEN    = 2;

  // Expected raster figures
  localparam int LINE_CLOCKS      = 8 * (H_SYNC_WIDTH + H_START + H_DISP_TILES + H_END_LEN + 4);
  localparam int HSYNC_LOW_CLOCKS = 8 * (H_SYNC_WIDTH + 1);
  localparam int FRAME_LINES      = (V_START + 2) + (V_DISP_LINES + 1) + V_END_LEN
                                    + (V_SYNC_WIDTH + 1);
  localparam int VSYNC_LOW_LINES  = V_SYNC_WIDTH + 1;
  localparam int FRAME_CLOCKS     = LINE_CLOCKS * FRAME_LINES;
  localparam int DISP_DOTS        = (V_DISP_LINES + 1) * (H_DISP_TILES + 1) * 8;  // Per frame

  localparam int WORDS_PER_RUN = 8;     // VRAM words per increment setting

  // Run budget of raster frames plus a worst-case line per bus access
  localparam int TEST_FRAMES    = 12;
  localparam int BUS_ACCESSES   = 450;
  localparam int TIMEOUT_CYCLES = 8 + TEST_FRAMES * FRAME_CLOCKS + BUS_ACCESSES * LINE_CLOCKS;

  logic      clock;
  logic      reset_N;
  logic      cs_n;
  logic      rd_n;
  logic      wr_n;
  bus_port_t a;
  byte_t     data_in;
  byte_t     data_out;
  logic      busy_n;
  logic      irq_n;
  logic      hsync_n;
  logic      vsync_n;
  pixel_t    vd;

  int        cycle_count;               // Clocks since time zero
  word_t     vram_model [65536];        // Words the tests have written

  `include "tb_vdc_tasks.svh"

  initial begin
    clock = 1'b0;
    forever #10 clock = ~clock;         // 50 MHz dot clock
  end

  vdc_top #(
    .H_SYNC_WIDTH (H_SYNC_WIDTH),
    .H_START      (H_START),
    .H_DISP_TILES (H_DISP_TILES),
    .H_END_LEN    (H_END_LEN),
    .V_SYNC_WIDTH (V_SYNC_WIDTH),
    .V_START      (V_START),
    .V_DISP_LINES (V_DISP_LINES),
    .V_END_LEN    (V_END_LEN)
  ) DUT (
    .clock    (clock),
    .reset_N  (reset_N),
    .cs_n     (cs_n),
    .rd_n     (rd_n),
    .wr_n     (wr_n),
    .a        (a),
    .data_in  (data_in),
    .data_out (data_out),
    .busy_n   (busy_n),
    .irq_n    (irq_n),
    .hsync_n  (hsync_n),
    .vsync_n  (vsync_n),
    .vd       (vd)
  );

  // Watchdog
  initial begin
    cycle_count = 0;
    while (cycle_count < TIMEOUT_CYCLES) begin
      @(posedge clock);
      cycle_count++;
    end
    abort_run("Timeout: the directed tests did not finish within the cycle limit");
  end

  ////////////////////////////////////////////////////////////////////////////
  // Test sequence

  initial begin
    reset_N    = 1'b0;
    cs_n       = 1'b1;                  // Bus idle
    rd_n       = 1'b1;
    wr_n       = 1'b1;
    a          = A_STATUS;
    data_in    = '0;
    void'($urandom(7816));
    repeat (8) @(posedge clock);
    reset_N <= 1'b1;

    check_reset_state();
    vram_increment_readback();
    sync_timing_measure();
    vblank_irq_sequence();
    background_pixels();

    $display("test passed");
    $finish;
  end

endmodule

//--- verilog.f
+incdir+tests
rtl/vdc_reg_pkg.sv
rtl/vdc_video_pkg.sv
rtl/vdc_timing_if.sv
rtl/vdc_vram.sv
rtl/vdc_cpu_port.sv
rtl/vdc_timing_gen.sv
rtl/vdc_vram_arbiter.sv
rtl/vdc_bg_fetch.sv
rtl/vdc_top.sv
tests/tb_vdc.sv
